// File: hdl/vgaLayoutPkg.sv
package vgaLayoutPkg;

    //////////////////////////////////////////////////////////////////////
    // screen and raster
    //////////////////////////////////////////////////////////////////////

    localparam int screenWidth  = 640;
    localparam int screenHeight = 480;

    typedef logic [9:0] coordT;
    typedef logic [3:0] digitT; // bcd, 10..15 stay dark

    //////////////////////////////////////////////////////////////////////
    // glyph boxes
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        coordT originX;
        coordT originY;
        coordT width;
        coordT height;
        coordT barWidth;
    } glyphGeomT;

    localparam glyphGeomT countdownGeom  = '{10'd270, 10'd150, 10'd100, 10'd180, 10'd20};
    localparam glyphGeomT scoreLeftGeom  = '{10'd275, 10'd190, 10'd50, 10'd90, 10'd10};
    localparam glyphGeomT scoreRightGeom = '{10'd340, 10'd190, 10'd50, 10'd90, 10'd10};
    localparam glyphGeomT timeLeftGeom   = '{10'd530, 10'd340, 10'd30, 10'd60, 10'd6};
    localparam glyphGeomT timeRightGeom  = '{10'd570, 10'd340, 10'd30, 10'd60, 10'd6};

    localparam int glyphCount = 5;

    typedef enum logic [2:0] {
        countdown,
        scoreLeft,
        scoreRight,
        timeLeft,
        timeRight
    } glyphIdxT;

    // bit 6 is segment a, bit 0 is segment g
    localparam logic [6:0] segPatterns [16] = '{
        7'b1111110, 7'b0110000, 7'b1101101, 7'b1111001,
        7'b0110011, 7'b1011011, 7'b1011111, 7'b1110000,
        7'b1111111, 7'b1111011,
        7'b0000000, 7'b0000000, 7'b0000000,
        7'b0000000, 7'b0000000, 7'b0000000
    };

endpackage

// File: hdl/vgaColorPkg.sv
package vgaColorPkg;

    //////////////////////////////////////////////////////////////////////
    // colour and theme
    //////////////////////////////////////////////////////////////////////

    typedef logic [11:0] rgbT; // r in [11:8], g in [7:4], b in [3:0]
    typedef logic [1:0] themeT;

    localparam rgbT blackRgb = 12'h000;

    // indexed by theme
    localparam rgbT bgColors [4] = '{12'h000, 12'hfff, 12'he7d, 12'h000};
    localparam rgbT fgColors [4] = '{12'hfff, 12'h000, 12'h00f, 12'hfff};

    //////////////////////////////////////////////////////////////////////
    // game flow
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        rst    = 4'd0,
        bRst   = 4'd1,
        bPlay  = 4'd2,
        stage1 = 4'd3,
        stage2 = 4'd4,
        stage3 = 4'd5,
        pmode  = 4'd6,
        win    = 4'd7,
        lose   = 4'd8,
        finish = 4'd9
    } gameStateT;

    // what the palette stage has to draw
    typedef enum logic [1:0] {
        blankScreen,
        countdownScreen,
        scoreScreen,
        backgroundScreen
    } screenT;

endpackage

// File: hdl/pixelStageIf.sv
`timescale 1ns/1ps

interface pixelStageIf;
    import vgaLayoutPkg::*;
    import vgaColorPkg::*;

    coordT hPos;
    coordT vPos;
    logic visible;
    screenT screen;
    themeT theme;
    digitT [glyphCount-1:0] digits; // slot order of glyphIdxT

    modport ctrl (
        output hPos,
        output vPos,
        output visible,
        output screen,
        output theme,
        output digits
    );

    // digit value comes in on its own port
    modport glyph (
        input hPos,
        input vPos
    );

    modport palette (
        input visible,
        input screen,
        input theme
    );

endinterface

// File: hdl/pixelControl.sv
`timescale 1ns/1ps

module pixelControl (
    input logic clk,
    input logic reset,
    input vgaLayoutPkg::coordT hCnt,
    input vgaLayoutPkg::coordT vCnt,
    input logic valid,
    input vgaColorPkg::themeT theme,
    input vgaColorPkg::gameStateT state,
    input vgaLayoutPkg::digitT score0,
    input vgaLayoutPkg::digitT score1,
    input vgaLayoutPkg::digitT cnt0,
    input vgaLayoutPkg::digitT cnt1,
    pixelStageIf.ctrl stage
);
    import vgaLayoutPkg::*;
    import vgaColorPkg::*;

    screenT nextScreen;

    // state to screen
    always_comb begin
        case (state)
            bRst:          nextScreen = blankScreen;
            bPlay:         nextScreen = countdownScreen;
            stage1, pmode: nextScreen = scoreScreen;
            default:       nextScreen = backgroundScreen; // incl. codes 10..15
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage.visible <= 1'b0;
            stage.screen  <= blankScreen;
        end else begin
            stage.visible <= valid;
            stage.screen  <= nextScreen;
        end
    end

    always_ff @(posedge clk) begin
        stage.hPos  <= hCnt;
        stage.vPos  <= vCnt;
        stage.theme <= theme;

        // left score box shows player 1
        stage.digits[countdown]  <= cnt0;
        stage.digits[scoreLeft]  <= score1;
        stage.digits[scoreRight] <= score0;
        stage.digits[timeLeft]   <= cnt1;
        stage.digits[timeRight]  <= cnt0;
    end

endmodule

// File: hdl/digitGlyph.sv
`timescale 1ns/1ps

module digitGlyph #(
    parameter vgaLayoutPkg::glyphGeomT geom = vgaLayoutPkg::countdownGeom
) (
    pixelStageIf.glyph stage,
    input vgaLayoutPkg::digitT digit,
    output logic lit
);
    import vgaLayoutPkg::*;

    localparam coordT boxW = geom.width;
    localparam coordT boxH = geom.height;
    localparam coordT barW = geom.barWidth;

    localparam coordT halfH      = boxH / 2;
    localparam coordT rightEdge  = boxW - barW;
    localparam coordT bottomEdge = boxH - barW;
    localparam coordT midLo      = (boxH - barW) / 2; // middle bar
    localparam coordT midHi      = (boxH + barW) / 2;

    coordT relX;
    coordT relY;
    logic inBox;
    logic [6:0] segHit;

    // left of or above the origin wraps to a large value
    assign relX = stage.hPos - geom.originX;
    assign relY = stage.vPos - geom.originY;

    assign inBox = (relX < boxW) && (relY < boxH);

    always_comb begin
        segHit[6] = relY < barW; // a
        segHit[5] = (relX >= rightEdge) && (relY < halfH); // b
        segHit[4] = (relX >= rightEdge) && (relY >= halfH); // c
        segHit[3] = relY >= bottomEdge; // d
        segHit[2] = (relX < barW) && (relY >= halfH); // e
        segHit[1] = (relX < barW) && (relY < halfH); // f
        segHit[0] = (relY >= midLo) && (relY < midHi); // g
    end

    assign lit = inBox && |(segHit & segPatterns[digit]);

endmodule

// File: hdl/themePalette.sv
`timescale 1ns/1ps

module themePalette (
    input logic clk,
    input logic reset,
    pixelStageIf.palette stage,
    input logic [vgaLayoutPkg::glyphCount-1:0] lit,
    output vgaColorPkg::rgbT rgb
);
    import vgaLayoutPkg::*;
    import vgaColorPkg::*;

    rgbT bgRgb;
    rgbT fgRgb;
    rgbT nextRgb;
    logic scoreLit;

    assign bgRgb = bgColors[stage.theme];
    assign fgRgb = fgColors[stage.theme];

    // any of the four scoreboard digits
    assign scoreLit = lit[scoreLeft] | lit[scoreRight] | lit[timeLeft] | lit[timeRight];

    always_comb begin
        if (!stage.visible) begin
            nextRgb = blackRgb;
        end else begin
            case (stage.screen)
                blankScreen: begin
                    nextRgb = blackRgb;
                end
                countdownScreen: begin
                    nextRgb = lit[countdown] ? fgRgb : bgRgb;
                end
                scoreScreen: begin
                    nextRgb = scoreLit ? fgRgb : bgRgb;
                end
                default: begin
                    nextRgb = bgRgb;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rgb <= blackRgb;
        end else begin
            rgb <= nextRgb;
        end
    end

endmodule

// File: hdl/vgaPixelGen.sv
`timescale 1ns/1ps

module vgaPixelGen (
    input logic clk,
    input logic reset,
    input vgaLayoutPkg::coordT hCnt,
    input vgaLayoutPkg::coordT vCnt,
    input logic valid,
    input vgaColorPkg::themeT theme,
    input vgaColorPkg::gameStateT state,
    input vgaLayoutPkg::digitT score0,
    input vgaLayoutPkg::digitT score1,
    input vgaLayoutPkg::digitT cnt0,
    input vgaLayoutPkg::digitT cnt1,
    output logic [3:0] vgaRed,
    output logic [3:0] vgaGreen,
    output logic [3:0] vgaBlue
);
    import vgaLayoutPkg::*;
    import vgaColorPkg::*;

    pixelStageIf stageIf ();

    logic [glyphCount-1:0] lit;
    rgbT rgb;

    //////////////////////////////////////////////////////////////////////
    // stage 1: input register and screen decode
    //////////////////////////////////////////////////////////////////////

    pixelControl i_pixelControl (
        .clk    (clk),
        .reset  (reset),
        .hCnt   (hCnt),
        .vCnt   (vCnt),
        .valid  (valid),
        .theme  (theme),
        .state  (state),
        .score0 (score0),
        .score1 (score1),
        .cnt0   (cnt0),
        .cnt1   (cnt1),
        .stage  (stageIf)
    );

    // one hit test per digit box
    digitGlyph #(.geom(countdownGeom)) i_countdownGlyph (
        .stage (stageIf),
        .digit (stageIf.digits[countdown]),
        .lit   (lit[countdown])
    );

    digitGlyph #(.geom(scoreLeftGeom)) i_scoreLeftGlyph (
        .stage (stageIf),
        .digit (stageIf.digits[scoreLeft]),
        .lit   (lit[scoreLeft])
    );

    digitGlyph #(.geom(scoreRightGeom)) i_scoreRightGlyph (
        .stage (stageIf),
        .digit (stageIf.digits[scoreRight]),
        .lit   (lit[scoreRight])
    );

    digitGlyph #(.geom(timeLeftGeom)) i_timeLeftGlyph (
        .stage (stageIf),
        .digit (stageIf.digits[timeLeft]),
        .lit   (lit[timeLeft])
    );

    digitGlyph #(.geom(timeRightGeom)) i_timeRightGlyph (
        .stage (stageIf),
        .digit (stageIf.digits[timeRight]),
        .lit   (lit[timeRight])
    );

    //////////////////////////////////////////////////////////////////////
    // stage 2: colour and output register
    //////////////////////////////////////////////////////////////////////

    themePalette i_themePalette (
        .clk   (clk),
        .reset (reset),
        .stage (stageIf),
        .lit   (lit),
        .rgb   (rgb)
    );

    assign {vgaRed, vgaGreen, vgaBlue} = rgb;

endmodule

// File: tb/vgaPixelGen_properties.sv
`timescale 1ns/1ps

module vgaPixelGen_properties (
    input logic clk,
    input logic reset,
    input logic valid,
    input logic stageVisible,
    input vgaColorPkg::rgbT rgb
);

    int failCount = 0;

    // dark for the first two cycles out of reset
    property resetDark;
        @(posedge clk) $fell(reset) |-> (rgb == 12'h000) ##1 (rgb == 12'h000);
    endproperty

    property validBlank;
        @(posedge clk) disable iff (reset) !valid |-> ##2 (rgb == 12'h000);
    endproperty

    property stageBlank;
        @(posedge clk) disable iff (reset) !stageVisible |=> (rgb == 12'h000);
    endproperty

    assert property (resetDark) else begin
        failCount++;
        $error("rgb left black within two cycles of reset");
    end

    assert property (validBlank) else begin
        failCount++;
        $error("rgb not black two cycles after valid low");
    end

    assert property (stageBlank) else begin
        failCount++;
        $error("rgb not black behind a blanked stage");
    end

endmodule

// File: tb/vgaPixelGenTb.sv
`timescale 1ns/1ps

module vgaPixelGenTb;
    import vgaLayoutPkg::*;
    import vgaColorPkg::*;

    localparam int clkPeriod   = 20;
    localparam int resetCycles = 8;
    localparam int numVectors  = 3000;
    localparam int timeoutCycles = resetCycles + numVectors + 50;
    localparam glyphGeomT boxGeoms [glyphCount] = '{countdownGeom, scoreLeftGeom,
        scoreRightGeom, timeLeftGeom, timeRightGeom};

    logic clk;
    logic reset;
    coordT hCnt;
    coordT vCnt;
    logic valid;
    themeT theme;
    gameStateT state;
    digitT score0;
    digitT score1;
    digitT cnt0;
    digitT cnt1;
    logic [3:0] vgaRed;
    logic [3:0] vgaGreen;
    logic [3:0] vgaBlue;

    logic [31:0] lfsrState = 32'h438d;
    int errorCount = 0;
    rgbT expQ [$]; // two pixels in flight

    vgaPixelGen i_vgaPixelGen (
        .clk(clk), .reset(reset), .hCnt(hCnt), .vCnt(vCnt), .valid(valid),
        .theme(theme), .state(state), .score0(score0), .score1(score1),
        .cnt0(cnt0), .cnt1(cnt1),
        .vgaRed(vgaRed), .vgaGreen(vgaGreen), .vgaBlue(vgaBlue)
    );

    bind vgaPixelGen vgaPixelGen_properties i_properties (
        .clk(clk), .reset(reset), .valid(valid),
        .stageVisible(stageIf.visible), .rgb(rgb)
    );

    //////////////////////////////////////////////////////////////////////
    // random source and reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            // taps 32, 22, 2, 1
            lfsrState = {lfsrState[30:0],
                         lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    function automatic logic glyphHit(input glyphGeomT g, input coordT x, input coordT y,
                                      input digitT d);
        int rx;
        int ry;
        int w;
        int h;
        int b;
        logic [6:0] on;
        logic hit;
        rx = int'(x) - int'(g.originX);
        ry = int'(y) - int'(g.originY);
        w = int'(g.width);
        h = int'(g.height);
        b = int'(g.barWidth);
        on = segPatterns[d];
        if (rx < 0 || ry < 0 || rx >= w || ry >= h) begin
            hit = 1'b0;
        end else begin
            hit = (on[6] && ry < b) || (on[3] && ry >= h - b)
                || (on[0] && ry >= (h - b) / 2 && ry < (h + b) / 2)
                || (on[5] && rx >= w - b && ry < h / 2) || (on[4] && rx >= w - b && ry >= h / 2)
                || (on[1] && rx < b && ry < h / 2) || (on[2] && rx < b && ry >= h / 2);
        end
        return hit;
    endfunction

    function automatic rgbT expectedRgb(input logic v, input gameStateT st, input themeT th,
                                        input coordT x, input coordT y, input digitT s0,
                                        input digitT s1, input digitT c0, input digitT c1);
        logic fg;
        if (!v || st == bRst) return 12'h000;
        case (st)
            bPlay: fg = glyphHit(countdownGeom, x, y, c0);
            stage1, pmode: fg = glyphHit(scoreLeftGeom, x, y, s1)
                || glyphHit(scoreRightGeom, x, y, s0)
                || glyphHit(timeLeftGeom, x, y, c1) || glyphHit(timeRightGeom, x, y, c0);
            default: fg = 1'b0;
        endcase
        return fg ? fgColors[th] : bgColors[th];
    endfunction

    //////////////////////////////////////////////////////////////////////
    // drive and check
    //////////////////////////////////////////////////////////////////////

    task automatic driveVector();
        glyphGeomT g;
        coordT x;
        coordT y;
        logic v;
        themeT th;
        gameStateT st;
        digitT s0;
        digitT s1;
        digitT c0;
        digitT c1;
        if (takeBits(1)) begin // inside a digit box
            g = boxGeoms[takeBits(3) % glyphCount];
            x = g.originX + coordT'(takeBits(8) % g.width);
            y = g.originY + coordT'(takeBits(8) % g.height);
        end else begin
            x = coordT'(takeBits(10) % screenWidth);
            y = coordT'(takeBits(9) % screenHeight);
        end
        v = (takeBits(3) != 0);
        th = themeT'(takeBits(2));
        case (takeBits(2))
            0: st = bPlay;
            1: st = stage1;
            2: st = pmode;
            default: st = gameStateT'(takeBits(4)); // any code, unused ones too
        endcase
        s0 = digitT'(takeBits(4));
        s1 = digitT'(takeBits(4));
        c0 = digitT'(takeBits(4));
        c1 = digitT'(takeBits(4));
        hCnt <= x;
        vCnt <= y;
        valid <= v;
        theme <= th;
        state <= st;
        score0 <= s0;
        score1 <= s1;
        cnt0 <= c0;
        cnt1 <= c1;
        expQ.push_back(expectedRgb(v, st, th, x, y, s0, s1, c0, c1));
    endtask

    task automatic checkChannel(input string name, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            errorCount++;
            $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic checkOutput(input rgbT exp);
        checkChannel("vgaRed", vgaRed, exp[11:8]);
        checkChannel("vgaGreen", vgaGreen, exp[7:4]);
        checkChannel("vgaBlue", vgaBlue, exp[3:0]);
    endtask

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        hCnt = '0;
        vCnt = '0;
        valid = 1'b1; // white background pending while in reset
        theme = 2'd1;
        state = rst;
        score0 = '0;
        score1 = '0;
        cnt0 = '0;
        cnt1 = '0;
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;
        expQ.push_back(12'h000); // output still black out of reset
        expQ.push_back(12'h000);
        for (int i = 0; i < numVectors; i++) begin
            driveVector();
            @(negedge clk);
            if (expQ.size() > 2) checkOutput(expQ.pop_front());
            @(posedge clk);
        end
        repeat (2) begin
            @(negedge clk);
            checkOutput(expQ.pop_front());
        end
        $display("Run complete with %0d check errors and %0d assertion failures",
                 errorCount, i_vgaPixelGen.i_properties.failCount);
        if (errorCount == 0 && i_vgaPixelGen.i_properties.failCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        #(timeoutCycles * clkPeriod);
        $display("Timeout: the run did not finish in the expected time");
        $display("Verification failed");
        $finish;
    end

endmodule

// File: vgaPixelGen.f
hdl/vgaLayoutPkg.sv
hdl/vgaColorPkg.sv
hdl/pixelStageIf.sv
hdl/pixelControl.sv
hdl/digitGlyph.sv
hdl/themePalette.sv
hdl/vgaPixelGen.sv
tb/vgaPixelGen_properties.sv
tb/vgaPixelGenTb.sv
